// File: verilog.f
source/div_pkg.sv
source/seq_divider.sv
source/axil_slave.sv
source/div_regs.sv
source/div_axil_top.sv
bench/tb_div_axil.sv

// File: bench/tb_div_axil.sv
// drives div_axil_top at data_width 16 with one bus access at a time; run ends at 6000 cycles
`default_nettype none

module tb_div_axil;

   localparam int data_width = 16;
   localparam int timeout_cycles = 6000;  // roughly twice the length of all tests

   logic        clk;
   logic        reset;
   logic [4:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [4:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   int errors = 0;
   int cycles = 0;
   int stall_max = 0;  // longest bready/rready hold per access

   div_axil_top #(.data_width(data_width)) i_div_axil_top (
      .clk(clk), .reset(reset),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= timeout_cycles)
      begin
         $display("timeout after %0d cycles, the DUT stopped answering", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // inputs change just after the edge, outputs are read there too
   task automatic tick;
      @(posedge clk);
      #10;
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
      begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   function automatic logic [15:0] model_quotient(input logic [15:0] a, input logic [15:0] b);
      if (b == 0)
         return 16'hffff;
      return a / b;
   endfunction

   function automatic logic [15:0] model_remainder(input logic [15:0] a, input logic [15:0] b);
      if (b == 0)
         return a;
      return a % b;
   endfunction

   function automatic int stall_len();
      if (stall_max == 0)
         return 0;
      return $urandom % (stall_max + 1);
   endfunction

   task automatic bus_write(input logic [4:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int hold;
      logic [1:0] held;
      hold = stall_len();
      awaddr = addr;
      wdata = data;
      awvalid = 1'b1;
      wvalid = 1'b1;
      while (!(awready && wready))
         tick;
      tick;  // accepted on this edge
      awvalid = 1'b0;
      wvalid = 1'b0;
      while (!bvalid)
         tick;
      held = bresp;
      repeat (hold)
      begin
         tick;
         if (!bvalid || bresp !== held)
         begin
            errors++;
            $display("write response at %0t dropped or changed while bready was low", $time);
         end
      end
      bready = 1'b1;
      tick;
      bready = 1'b0;
      resp = held;
   endtask

   task automatic bus_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int hold;
      hold = stall_len();
      araddr = addr;
      arvalid = 1'b1;
      while (!arready)
         tick;
      tick;
      arvalid = 1'b0;
      while (!rvalid)
         tick;
      data = rdata;
      resp = rresp;
      repeat (hold)
      begin
         tick;
         if (!rvalid || rdata !== data || rresp !== resp)
         begin
            errors++;
            $display("read response at %0t dropped or changed while rready was low", $time);
         end
      end
      rready = 1'b1;
      tick;
      rready = 1'b0;
   endtask

   task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
      logic [1:0] resp;
      bus_write(addr, data, resp);
      check_value("bresp", exp_resp, resp);
   endtask

   task automatic axil_read(input logic [4:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
      logic [31:0] data;
      logic [1:0] resp;
      bus_read(addr, data, resp);
      check_value("rdata", exp_data, data);
      check_value("rresp", exp_resp, resp);
   endtask

   task automatic wait_done;
      logic [31:0] status;
      logic [1:0] resp;
      status = '0;
      while (!status[1])  // bounded by the cycle counter
         bus_read(div_pkg::REG_STATUS, status, resp);
   endtask

   task automatic do_divide(input logic [15:0] a, input logic [15:0] b);
      logic [31:0] exp_status;
      exp_status = (b == 0) ? 32'h6 : 32'h2;  // done, plus div_zero
      axil_write(div_pkg::REG_DIVIDEND, {16'h0, a}, div_pkg::RESP_OKAY);
      axil_write(div_pkg::REG_DIVISOR, {16'h0, b}, div_pkg::RESP_OKAY);
      axil_write(div_pkg::REG_CTRL, 32'h1, div_pkg::RESP_OKAY);
      wait_done;
      axil_read(div_pkg::REG_QUOTIENT, {16'h0, model_quotient(a, b)}, div_pkg::RESP_OKAY);
      axil_read(div_pkg::REG_REMAINDER, {16'h0, model_remainder(a, b)}, div_pkg::RESP_OKAY);
      axil_read(div_pkg::REG_STATUS, exp_status, div_pkg::RESP_OKAY);
   endtask

   task automatic test_directed;
      do_divide(16'd100, 16'd7);
      do_divide(16'd65535, 16'd1);
      do_divide(16'd5, 16'd9);
      do_divide(16'd0, 16'd3);
      do_divide(16'd65535, 16'd65535);
   endtask

   task automatic test_div_zero;
      do_divide(16'd1234, 16'd0);
      do_divide(16'd50, 16'd5);  // div_zero must clear again
   endtask

   // second start and a new dividend arrive while the first division runs
   task automatic test_start_busy;
      axil_write(div_pkg::REG_DIVIDEND, 32'd1000, div_pkg::RESP_OKAY);
      axil_write(div_pkg::REG_DIVISOR, 32'd7, div_pkg::RESP_OKAY);
      axil_write(div_pkg::REG_CTRL, 32'h1, div_pkg::RESP_OKAY);
      axil_read(div_pkg::REG_STATUS, 32'h1, div_pkg::RESP_OKAY);
      axil_write(div_pkg::REG_DIVIDEND, 32'd5000, div_pkg::RESP_OKAY);
      axil_write(div_pkg::REG_CTRL, 32'h1, div_pkg::RESP_SLVERR);
      wait_done;
      axil_read(div_pkg::REG_STATUS, 32'h2, div_pkg::RESP_OKAY);
      axil_read(div_pkg::REG_QUOTIENT, {16'h0, model_quotient(1000, 7)}, div_pkg::RESP_OKAY);
      axil_read(div_pkg::REG_REMAINDER, {16'h0, model_remainder(1000, 7)}, div_pkg::RESP_OKAY);
   endtask

   task automatic test_unmapped;
      axil_write(5'h18, 32'h1234_5678, div_pkg::RESP_SLVERR);
      axil_read(5'h18, 32'h0, div_pkg::RESP_SLVERR);
      axil_write(5'h1C, 32'hffff_ffff, div_pkg::RESP_SLVERR);
      axil_read(5'h1C, 32'h0, div_pkg::RESP_SLVERR);
      // quotient still holds the 1000/7 result
      axil_write(div_pkg::REG_QUOTIENT, 32'h0000_dead, div_pkg::RESP_SLVERR);
      axil_read(div_pkg::REG_QUOTIENT, {16'h0, model_quotient(1000, 7)}, div_pkg::RESP_OKAY);
   endtask

   task automatic test_random;
      logic [15:0] a;
      logic [15:0] b;
      stall_max = 3;
      repeat (40)
      begin
         a = 16'($urandom);
         b = 16'($urandom);
         do_divide(a, b);
      end
      stall_max = 0;
   endtask

   initial
   begin
      void'($urandom(32'ha70a_c0f5));
      clk = 1'b0;
      reset = 1'b1;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      repeat (4) @(posedge clk);
      #10;
      reset = 1'b0;
      check_value("awready", 32'h1, awready);
      check_value("wready", 32'h1, wready);
      check_value("arready", 32'h1, arready);
      check_value("bvalid", 32'h0, bvalid);
      check_value("rvalid", 32'h0, rvalid);
      axil_read(div_pkg::REG_STATUS, 32'h0, div_pkg::RESP_OKAY);
      test_directed;
      test_div_zero;
      test_start_busy;
      test_unmapped;
      test_random;
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/div_axil_top.sv
// single divider behind AXI4-Lite at 5-bit offsets; data_width from 2 to 32, unsigned operands
`default_nettype none

module div_axil_top #(
   parameter int data_width = 16
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [4:0]                      awaddr,
   input  logic                            awvalid,
   output logic                            awready,
   input  logic [div_pkg::axil_data_w-1:0] wdata,
   input  logic                            wvalid,
   output logic                            wready,
   output logic [1:0]                      bresp,
   output logic                            bvalid,
   input  logic                            bready,
   input  logic [4:0]                      araddr,
   input  logic                            arvalid,
   output logic                            arready,
   output logic [div_pkg::axil_data_w-1:0] rdata,
   output logic [1:0]                      rresp,
   output logic                            rvalid,
   input  logic                            rready
);

   div_pkg::reg_req_t reg_req;
   div_pkg::reg_rsp_t reg_rsp;
   logic start, ready, done_tick;
   logic [data_width-1:0] dividend, divisor;
   logic [data_width-1:0] quotient, remainder;

   axil_slave i_axil_slave (
      .clk(clk), .reset(reset),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .reg_req(reg_req), .reg_rsp(reg_rsp)
   );

   div_regs #(.data_width(data_width)) i_div_regs (
      .clk(clk), .reset(reset),
      .reg_req(reg_req), .reg_rsp(reg_rsp),
      .ready(ready), .done_tick(done_tick),
      .quotient(quotient), .remainder(remainder),
      .start(start), .dividend(dividend), .divisor(divisor)
   );

   seq_divider #(.data_width(data_width)) i_seq_divider (
      .clk(clk), .reset(reset),
      .start(start), .dividend(dividend), .divisor(divisor),
      .ready(ready), .done_tick(done_tick),
      .quotient(quotient), .remainder(remainder)
   );

endmodule

`default_nettype wire

// File: source/div_regs.sv
// operands zero-extend on read and truncate on write; results hold until the next start
`default_nettype none

module div_regs #(
   parameter int data_width = 16
) (
   input  logic                  clk,
   input  logic                  reset,
   input  div_pkg::reg_req_t     reg_req,
   output div_pkg::reg_rsp_t     reg_rsp,
   input  logic                  ready,
   input  logic                  done_tick,
   input  logic [data_width-1:0] quotient,
   input  logic [data_width-1:0] remainder,
   output logic                  start,
   output logic [data_width-1:0] dividend,
   output logic [data_width-1:0] divisor
);

   logic [data_width-1:0] dividend_reg, divisor_reg;
   logic [data_width-1:0] quotient_reg, remainder_reg;
   logic done_flag;
   logic zero_flag;  // sticky until the next start
   logic zero_pend;  // divisor of the running division was zero
   logic wr_en;
   logic start_cmd;

   assign wr_en = reg_req.valid && reg_req.write;
   assign start_cmd = wr_en && (reg_req.addr == div_pkg::REG_CTRL) && reg_req.wdata[0];
   assign start = start_cmd && ready;  // ignored while busy

   assign dividend = dividend_reg;
   assign divisor = divisor_reg;

   always_ff @(posedge clk)
   begin
      if (wr_en && reg_req.addr == div_pkg::REG_DIVIDEND)
         dividend_reg <= reg_req.wdata[data_width-1:0];
      if (wr_en && reg_req.addr == div_pkg::REG_DIVISOR)
         divisor_reg <= reg_req.wdata[data_width-1:0];
      if (done_tick)
      begin
         quotient_reg <= quotient;
         remainder_reg <= remainder;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         done_flag <= 1'b0;
         zero_flag <= 1'b0;
         zero_pend <= 1'b0;
      end
      else if (start)
      begin
         done_flag <= 1'b0;
         zero_flag <= 1'b0;
         zero_pend <= (divisor_reg == '0);
      end
      else if (done_tick)
      begin
         done_flag <= 1'b1;
         zero_flag <= zero_pend;
      end
   end

   // response and read mux
   always_comb
   begin
      reg_rsp.rdata = '0;
      reg_rsp.resp = div_pkg::RESP_OKAY;
      case (reg_req.addr)
         div_pkg::REG_CTRL:
            if (start_cmd && !ready)
               reg_rsp.resp = div_pkg::RESP_SLVERR;  // start while busy
         div_pkg::REG_DIVIDEND:
            reg_rsp.rdata[data_width-1:0] = dividend_reg;
         div_pkg::REG_DIVISOR:
            reg_rsp.rdata[data_width-1:0] = divisor_reg;
         div_pkg::REG_STATUS:
         begin
            reg_rsp.rdata[2:0] = {zero_flag, done_flag, !ready};
            if (reg_req.write)
               reg_rsp.resp = div_pkg::RESP_SLVERR;  // read-only
         end
         div_pkg::REG_QUOTIENT:
         begin
            reg_rsp.rdata[data_width-1:0] = quotient_reg;
            if (reg_req.write)
               reg_rsp.resp = div_pkg::RESP_SLVERR;
         end
         div_pkg::REG_REMAINDER:
         begin
            reg_rsp.rdata[data_width-1:0] = remainder_reg;
            if (reg_req.write)
               reg_rsp.resp = div_pkg::RESP_SLVERR;
         end
         default:
            reg_rsp.resp = div_pkg::RESP_SLVERR;  // unmapped offset
      endcase
   end

endmodule

`default_nettype wire

// File: source/axil_slave.sv
// one outstanding access per channel; no wstrb or prot, every write takes the full word
`default_nettype none

module axil_slave (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [4:0]                          awaddr,
   input  logic                                awvalid,
   output logic                                awready,
   input  logic [div_pkg::axil_data_w-1:0]     wdata,
   input  logic                                wvalid,
   output logic                                wready,
   output logic [1:0]                          bresp,
   output logic                                bvalid,
   input  logic                                bready,
   input  logic [4:0]                          araddr,
   input  logic                                arvalid,
   output logic                                arready,
   output logic [div_pkg::axil_data_w-1:0]     rdata,
   output logic [1:0]                          rresp,
   output logic                                rvalid,
   input  logic                                rready,
   output div_pkg::reg_req_t                   reg_req,
   input  div_pkg::reg_rsp_t                   reg_rsp
);

   logic wr_go;  // write accepted this cycle
   logic rd_go;  // read accepted this cycle

   // address and data are taken together, so nothing is buffered
   assign awready = !bvalid;
   assign wready = !bvalid;
   assign wr_go = awvalid && awready && wvalid && wready;

   // a write in the same cycle pushes the read back by one
   assign arready = !rvalid && !wr_go;
   assign rd_go = arvalid && arready;

   always_comb
   begin
      reg_req.valid = wr_go || rd_go;
      reg_req.write = wr_go;
      reg_req.addr = div_pkg::reg_addr_t'(wr_go ? awaddr : araddr);
      reg_req.wdata = wdata;
   end

   // write response channel
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         bvalid <= 1'b0;
      else if (wr_go)
         bvalid <= 1'b1;
      else if (bready)
         bvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (wr_go)
         bresp <= reg_rsp.resp;
   end

   // read data channel
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         rvalid <= 1'b0;
      else if (rd_go)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (rd_go)
      begin
         rdata <= reg_rsp.rdata;  // captured once, held while stalled
         rresp <= reg_rsp.resp;
      end
   end

   a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid && $stable(bresp));

   a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

   // the register block sees one access per cycle
   a_one_req: assert property (@(posedge clk) disable iff (reset)
      !(wr_go && rd_go));

endmodule

`default_nettype wire

// File: source/seq_divider.sv
// unsigned only, data_width 2 to 32; a zero divisor yields all-ones quotient and the dividend as remainder
`default_nettype none

module seq_divider #(
   parameter int data_width = 16
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  start,
   input  logic [data_width-1:0] dividend,
   input  logic [data_width-1:0] divisor,
   output logic                  ready,
   output logic                  done_tick,
   output logic [data_width-1:0] quotient,
   output logic [data_width-1:0] remainder
);

   localparam int cnt_w = $clog2(data_width);

   div_pkg::div_state_t state_reg, state_next;
   logic [data_width:0]   rh_reg, rh_next;  // partial remainder, spare msb for the shift
   logic [data_width:0]   rh_tmp;
   logic [data_width-1:0] rl_reg, rl_next;  // dividend bits out, quotient bits in
   logic [data_width-1:0] d_reg, d_next;
   logic [cnt_w-1:0]      n_reg, n_next;    // shift steps left before the last one
   logic                  q_bit;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_reg <= div_pkg::DIV_IDLE;
         n_reg <= '0;
      end
      else
      begin
         state_reg <= state_next;
         n_reg <= n_next;
      end
   end

   // datapath registers
   always_ff @(posedge clk)
   begin
      rh_reg <= rh_next;
      rl_reg <= rl_next;
      d_reg <= d_next;
   end

   always_comb
   begin
      state_next = state_reg;
      rh_next = rh_reg;
      rl_next = rl_reg;
      d_next = d_reg;
      n_next = n_reg;
      case (state_reg)
         div_pkg::DIV_IDLE:
         begin
            if (start)
            begin
               // dividend msb goes straight into the remainder
               rh_next = {{data_width{1'b0}}, dividend[data_width-1]};
               rl_next = {dividend[data_width-2:0], 1'b0};
               d_next = divisor;
               n_next = cnt_w'(data_width - 1);
               state_next = div_pkg::DIV_OP;
            end
         end
         div_pkg::DIV_OP:
         begin
            rl_next = {rl_reg[data_width-2:0], q_bit};
            rh_next = {rh_tmp[data_width-1:0], rl_reg[data_width-1]};
            n_next = n_reg - 1'b1;
            if (n_reg == 1)
               state_next = div_pkg::DIV_LAST;
         end
         div_pkg::DIV_LAST:
         begin
            rl_next = {rl_reg[data_width-2:0], q_bit};
            rh_next = rh_tmp;  // no shift on the final step
            state_next = div_pkg::DIV_DONE;
         end
         default:
            state_next = div_pkg::DIV_IDLE;  // done lasts one cycle
      endcase
   end

   // compare and subtract
   always_comb
   begin
      if (rh_reg >= {1'b0, d_reg})
      begin
         rh_tmp = rh_reg - {1'b0, d_reg};
         q_bit = 1'b1;
      end
      else
      begin
         rh_tmp = rh_reg;
         q_bit = 1'b0;
      end
   end

   assign ready = (state_reg == div_pkg::DIV_IDLE);
   assign done_tick = (state_reg == div_pkg::DIV_DONE);
   assign quotient = rl_reg;
   assign remainder = rh_reg[data_width-1:0];  // msb is always clear here

   a_done_single: assert property (@(posedge clk) disable iff (reset)
      done_tick |=> !done_tick);

   // the register block may only start an idle divider
   a_start_ready: assert property (@(posedge clk) disable iff (reset)
      start |-> ready);

endmodule

`default_nettype wire

// File: source/div_pkg.sv
// shared bus and divider types; register offsets assume a 5-bit word-aligned AXI4-Lite address
`default_nettype none

package div_pkg;

   // bus word, independent of the divider operand width
   localparam int axil_data_w = 32;

   // register offsets as seen on awaddr and araddr
   typedef enum logic [4:0] {
      REG_CTRL      = 5'h00,  // bit 0 starts a division
      REG_DIVIDEND  = 5'h04,
      REG_DIVISOR   = 5'h08,
      REG_STATUS    = 5'h0C,  // busy, done, div_zero
      REG_QUOTIENT  = 5'h10,
      REG_REMAINDER = 5'h14
   } reg_addr_t;

   // AXI response codes in use
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } resp_t;

   // one register access, valid for a single cycle
   typedef struct packed {
      logic                   valid;
      logic                   write;
      reg_addr_t              addr;
      logic [axil_data_w-1:0] wdata;
   } reg_req_t;

   // answer to reg_req_t in the same cycle
   typedef struct packed {
      logic [axil_data_w-1:0] rdata;
      resp_t                  resp;
   } reg_rsp_t;

   // restoring divider sequence
   typedef enum logic [1:0] {
      DIV_IDLE,
      DIV_OP,
      DIV_LAST,
      DIV_DONE
   } div_state_t;

endpackage

`default_nettype wire
